// File: dv/soc_bus_input.txt
// op codes 0 write, 1 read, 2 wait irq, 3 ack irq, 4 ext pulse, 5 check irq level, f end
// columns are op, byte address, write data or expected value, byte select
// sram round trip
0 01000000 11223344 f
0 01000ffc deadbeef f
0 01000000 000000ee 1
0 01000ffc 00cc0000 4
1 01000000 112233ee f
1 01000ffc deccbeef f
// unmapped on the cpu bus and the peripheral bus
0 20000000 12345678 f
1 20000000 00000000 f
1 00000000 00000000 f
0 f3000010 ffffffff f
1 f2000000 00000000 f
1 f000000c 00000000 f
// timer registers through the bridge
0 f1000004 00000014 f
1 f1000004 00000014 f
1 f1000008 00000000 f
1 f1000000 00000000 f
// timer interrupt
0 f0000000 00000001 f
0 f1000000 00000001 f
2 00000000 00000000 0
0 f1000000 00000000 f
1 f0000004 00000001 f
3 00000000 00000000 0
1 f0000008 00000000 f
1 f0000004 00000000 f
// timer pending while the pin pulses
0 f1000000 00000001 f
2 00000000 00000000 0
0 f1000000 00000000 f
4 00000000 00000000 0
1 f0000004 00000003 f
0 f0000000 00000003 f
3 00000000 00000000 0
1 f0000008 00000000 f
3 00000000 00000000 0
1 f0000008 00000001 f
5 00000000 00000000 0
1 f0000004 00000000 f
// masked pin
0 f0000000 00000000 f
4 00000000 00000000 0
1 f0000004 00000002 f
5 00000000 00000000 0
0 f0000004 00000002 f
1 f0000004 00000000 f
f 00000000 00000000 0

// File: dv/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;

	localparam int          CLK_PERIOD = 10;
	localparam int          MAX_TRANS  = 64;
	localparam logic [7:0]  LFSR_SEED  = 8'd37;
	localparam string       STIM_FILE  = "dv/soc_bus_input.txt";

	// operation codes of the data file
	localparam logic [31:0] OP_WRITE     = 32'h0;
	localparam logic [31:0] OP_READ      = 32'h1;
	localparam logic [31:0] OP_WAIT_IRQ  = 32'h2;
	localparam logic [31:0] OP_ACK_IRQ   = 32'h3;
	localparam logic [31:0] OP_EXT_PULSE = 32'h4;
	localparam logic [31:0] OP_CHECK_IRQ = 32'h5;
	localparam logic [31:0] OP_END       = 32'hf;

	logic              clk;
	logic              reset;
	soc_pkg::bus_req_t cpu_req;
	soc_pkg::bus_rsp_t cpu_rsp;
	logic              ext_irq;
	logic              cpu_irq;
	logic              cpu_irq_ack;

	// four words per transaction
	logic [31:0] stim [0:4*MAX_TRANS-1];
	logic [7:0]  lfsr_state;
	int          n_trans;
	logic        stim_loaded;

	soc_bus_top dut_i (
		.clk           (clk),
		.reset         (reset),
		.cpu_req_i     (cpu_req),
		.cpu_rsp_o     (cpu_rsp),
		.ext_irq_i     (ext_irq),
		.cpu_irq_o     (cpu_irq),
		.cpu_irq_ack_i (cpu_irq_ack)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	// galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		logic [7:0] shifted;
		shifted = state >> 1;
		if (state[0]) begin
			shifted = shifted ^ 8'hb8;
		end
		return shifted;
	endfunction

	// two lfsr bits give 0 to 3 idle cycles
	task automatic draw_gap(output int gap);
		logic [1:0] bits;
		for (int i = 0; i < 2; i++) begin
			bits[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		gap = int'(bits);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s expected %h actual %h",
				$time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic stop_with_error(input string reason);
		$display("error at %0t ns: %s", $time, reason);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	// one bus cycle, request held until ack
	task automatic bus_access(input logic we, input logic [31:0] addr,
		input logic [31:0] wdat, input logic [3:0] sel, output logic [31:0] rdat);
		cpu_req.adr = addr[31:2];
		cpu_req.dat = wdat;
		cpu_req.we  = we;
		cpu_req.sel = sel;
		cpu_req.stb = 1'b1;
		do begin
			@(negedge clk);
		end while (!cpu_rsp.ack);
		rdat    = cpu_rsp.dat;
		cpu_req = '0;
	endtask

	task automatic run_transaction(input int idx);
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic [31:0] rdat;
		op   = stim[4*idx];
		addr = stim[4*idx+1];
		dat  = stim[4*idx+2];
		sel  = stim[4*idx+3][3:0];
		case (op)
			OP_WRITE: bus_access(1'b1, addr, dat, sel, rdat);
			OP_READ: begin
				bus_access(1'b0, addr, 32'h0, sel, rdat);
				check_value($sformatf("cpu_rsp_o.dat at %h", addr), dat, rdat);
			end
			OP_WAIT_IRQ: begin
				while (!cpu_irq) begin
					@(negedge clk);
				end
			end
			OP_ACK_IRQ: begin
				cpu_irq_ack = 1'b1;
				@(negedge clk);
				cpu_irq_ack = 1'b0;
			end
			OP_EXT_PULSE: begin
				ext_irq = 1'b1;
				@(negedge clk);
				ext_irq = 1'b0;
			end
			OP_CHECK_IRQ: begin
				// pending to request takes two registered edges
				repeat (2) @(negedge clk);
				check_value("cpu_irq_o", dat, {31'b0, cpu_irq});
			end
			default: stop_with_error($sformatf("unknown operation %h in transaction %0d",
				op, idx));
		endcase
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		int gap;
		reset       = 1'b1;
		cpu_req     = '0;
		ext_irq     = 1'b0;
		cpu_irq_ack = 1'b0;
		lfsr_state  = LFSR_SEED;
		n_trans     = 0;
		stim_loaded = 1'b0;
		$readmemh(STIM_FILE, stim);
		while (n_trans < MAX_TRANS && stim[4*n_trans] !== OP_END) begin
			n_trans++;
		end
		if (n_trans == 0 || n_trans == MAX_TRANS) begin
			stop_with_error("the data file is empty or has no end marker");
		end
		stim_loaded = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < n_trans; i++) begin
			draw_gap(gap);
			repeat (gap) @(negedge clk);
			run_transaction(i);
		end
		@(negedge clk);
		$display("TEST OK");
		$finish;
	end

	// watchdog sized by the number of transactions
	initial begin
		wait (stim_loaded);
		repeat (40 * n_trans + 200) @(posedge clk);
		stop_with_error("watchdog expired, the bus or interrupt never responded");
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_soc_bus \
	-Mdir build -o sim_soc_bus > build.log 2>&1 \
	&& ./build/sim_soc_bus > sim.log 2>&1 \
	&& grep -qx "TEST OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: source/bus_bridge.sv
`timescale 1ns/1ps

module bus_bridge (
	input  logic              clk,
	input  logic              reset,
	input  soc_pkg::bus_req_t in_req_i,
	output soc_pkg::bus_rsp_t in_rsp_o,
	output soc_pkg::bus_req_t out_req_o,
	input  soc_pkg::bus_rsp_t out_rsp_i
);

	soc_pkg::bus_req_t req_q;
	logic [31:0]       rsp_dat_q;
	logic              out_stb_q;
	logic              in_ack_q;
	logic              capture;
	logic              done;

	// take a new request only when idle and not in the input ack cycle
	assign capture = in_req_i.stb && !out_stb_q && !in_ack_q;
	assign done    = out_stb_q && out_rsp_i.ack;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_stb_q <= 1'b0;
			in_ack_q  <= 1'b0;
		end else begin
			in_ack_q <= done;
			if (done) begin
				out_stb_q <= 1'b0;
			end else if (capture) begin
				out_stb_q <= 1'b1;
			end
		end
	end

	// payload side
	always_ff @(posedge clk) begin
		if (capture) begin
			req_q <= in_req_i;
		end
		if (done) begin
			rsp_dat_q <= out_rsp_i.dat;
		end
	end

	always_comb begin
		out_req_o     = req_q;
		out_req_o.stb = out_stb_q;
	end

	assign in_rsp_o.dat = rsp_dat_q;
	assign in_rsp_o.ack = in_ack_q;

	// request held steady under back-pressure
	a_out_req_stable: assert property (@(posedge clk) disable iff (reset)
		out_req_o.stb && !out_rsp_i.ack |=> out_req_o.stb && $stable(out_req_o));

endmodule

// File: source/bus_sram.sv
`timescale 1ns/1ps

module bus_sram (
	input  logic              clk,
	input  logic              reset,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o
);

	localparam int DEPTH = 1 << soc_pkg::SRAM_ADR_BITS;

	logic [31:0] mem [0:DEPTH-1];
	logic [31:0] rd_dat_q;
	logic        ack_q;
	logic        access;
	logic [soc_pkg::SRAM_ADR_BITS-1:0] index;

	// one access per request, the ack cycle blocks a second one
	assign access = req_i.stb && !ack_q;
	assign index  = req_i.adr[soc_pkg::SRAM_ADR_BITS-1:0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// byte lane writes
	always_ff @(posedge clk) begin
		if (access && req_i.we) begin
			for (int b = 0; b < 4; b++) begin
				if (req_i.sel[b]) begin
					mem[index][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rd_dat_q <= mem[index];
		end
	end

	assign rsp_o.dat = rd_dat_q;
	assign rsp_o.ack = ack_q;

	// every ack answers a strobe seen on the edge before
	a_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
		rsp_o.ack |-> $past(req_i.stb));

endmodule

// File: source/interval_timer.sv
`timescale 1ns/1ps

module interval_timer (
	input  logic              clk,
	input  logic              reset,
	output logic              irq_o,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o
);

	logic        enable_q;
	logic [31:0] compare_q;
	logic [31:0] counter_q;
	logic        irq_q;
	logic        ack_q;
	logic [31:0] rd_dat_q;

	logic        access;
	logic        wr_en;
	logic        ctrl_wr;
	logic        match;

	assign access  = req_i.stb && !ack_q;
	assign wr_en   = access && req_i.we;
	assign ctrl_wr = wr_en && req_i.sel[0] && req_i.adr[1:0] == soc_pkg::TIMER_REG_CONTROL;
	assign match   = enable_q && (counter_q == compare_q);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			enable_q  <= 1'b0;
			compare_q <= '0;
			counter_q <= '0;
			irq_q     <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			ack_q <= access;
			irq_q <= match;
			// counter, wraps on match, period compare + 1
			if (ctrl_wr || match) begin
				counter_q <= '0;
			end else if (enable_q) begin
				counter_q <= counter_q + 32'd1;
			end
			if (ctrl_wr) begin
				enable_q <= req_i.dat[0];
			end
			if (wr_en && req_i.adr[1:0] == soc_pkg::TIMER_REG_COMPARE) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.sel[b]) begin
						compare_q[8*b +: 8] <= req_i.dat[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			case (req_i.adr[1:0])
				soc_pkg::TIMER_REG_CONTROL: rd_dat_q <= 32'(enable_q);
				soc_pkg::TIMER_REG_COMPARE: rd_dat_q <= compare_q;
				soc_pkg::TIMER_REG_COUNTER: rd_dat_q <= counter_q;
				default:                    rd_dat_q <= '0;
			endcase
		end
	end

	assign irq_o     = irq_q;
	assign rsp_o.dat = rd_dat_q;
	assign rsp_o.ack = ack_q;

	// single-cycle pulse unless the period is one cycle
	a_irq_pulse: assert property (@(posedge clk) disable iff (reset)
		irq_o && compare_q != 32'd0 |=> !irq_o);

endmodule

// File: source/irq_controller.sv
`timescale 1ns/1ps

module irq_controller (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [soc_pkg::IRQ_NUM-1:0] irq_i,
	output logic                        cpu_irq_o,
	input  logic                        cpu_irq_ack_i,
	input  soc_pkg::bus_req_t           req_i,
	output soc_pkg::bus_rsp_t           rsp_o
);

	logic [soc_pkg::IRQ_NUM-1:0]     enable_q;
	logic [soc_pkg::IRQ_NUM-1:0]     pending_q;
	logic [soc_pkg::IRQ_ID_BITS-1:0] factor_q;
	logic                            irq_q;
	logic                            ack_q;
	logic [31:0]                     rd_dat_q;

	logic [soc_pkg::IRQ_NUM-1:0]     active;
	logic [soc_pkg::IRQ_ID_BITS-1:0] ack_id;
	logic [soc_pkg::IRQ_NUM-1:0]     ack_clr;
	logic [soc_pkg::IRQ_NUM-1:0]     wr_clr;
	logic                            access;
	logic                            wr_en;
	logic                            cpu_ack_hit;

	assign access      = req_i.stb && !ack_q;
	assign wr_en       = access && req_i.we && req_i.sel[0];
	assign active      = pending_q & enable_q;
	assign cpu_ack_hit = cpu_irq_ack_i && (|active);

	// fixed priority with the lowest index winning
	always_comb begin
		ack_id = '0;
		for (int i = soc_pkg::IRQ_NUM - 1; i >= 0; i--) begin
			if (active[i]) begin
				ack_id = soc_pkg::IRQ_ID_BITS'(i);
			end
		end
	end

	assign ack_clr = cpu_ack_hit ? (soc_pkg::IRQ_NUM'(1) << ack_id) : '0;
	assign wr_clr  = (wr_en && req_i.adr[1:0] == soc_pkg::IRC_REG_PENDING)
		? req_i.dat[soc_pkg::IRQ_NUM-1:0] : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			enable_q  <= '0;
			pending_q <= '0;
			factor_q  <= '0;
			irq_q     <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			ack_q     <= access;
			irq_q     <= |active;
			// a new request wins over a clear in the same cycle
			pending_q <= (pending_q & ~(ack_clr | wr_clr)) | irq_i;
			if (cpu_ack_hit) begin
				factor_q <= ack_id;
			end
			if (wr_en && req_i.adr[1:0] == soc_pkg::IRC_REG_ENABLE) begin
				enable_q <= req_i.dat[soc_pkg::IRQ_NUM-1:0];
			end
		end
	end

	// ----------------------------------------
	// register read
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (access) begin
			case (req_i.adr[1:0])
				soc_pkg::IRC_REG_ENABLE:  rd_dat_q <= 32'(enable_q);
				soc_pkg::IRC_REG_PENDING: rd_dat_q <= 32'(pending_q);
				soc_pkg::IRC_REG_FACTOR:  rd_dat_q <= 32'(factor_q);
				default:                  rd_dat_q <= '0;
			endcase
		end
	end

	assign cpu_irq_o = irq_q;
	assign rsp_o.dat = rd_dat_q;
	assign rsp_o.ack = ack_q;

	// recorded factor was enabled and pending, and no lower one was
	a_ack_lowest: assert property (@(posedge clk) disable iff (reset)
		cpu_ack_hit |=> (|($past(active) & (soc_pkg::IRQ_NUM'(1) << factor_q)))
			&& (($past(active) & ~({soc_pkg::IRQ_NUM{1'b1}} << factor_q)) == '0));

endmodule

// File: source/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
	input  logic              clk,
	input  logic              reset,
	input  soc_pkg::bus_req_t cpu_req_i,
	output soc_pkg::bus_rsp_t cpu_rsp_o,
	input  logic              ext_irq_i,
	output logic              cpu_irq_o,
	input  logic              cpu_irq_ack_i
);

	soc_pkg::bus_req_t sram_req;
	soc_pkg::bus_rsp_t sram_rsp;
	soc_pkg::bus_req_t bridge_req;
	soc_pkg::bus_rsp_t bridge_rsp;

	soc_pkg::bus_req_t peri_req;
	soc_pkg::bus_rsp_t peri_rsp;
	soc_pkg::bus_req_t irc_req;
	soc_pkg::bus_rsp_t irc_rsp;
	soc_pkg::bus_req_t timer_req;
	soc_pkg::bus_rsp_t timer_rsp;

	logic                        timer_irq;
	logic [soc_pkg::IRQ_NUM-1:0] irq_vec;

	// ----------------------------------------
	// cpu bus decoder
	// ----------------------------------------

	// adr[29:22] is byte address 31:24
	always_comb begin
		sram_req       = cpu_req_i;
		sram_req.stb   = 1'b0;
		bridge_req     = cpu_req_i;
		bridge_req.stb = 1'b0;
		if (cpu_req_i.adr[29:22] == soc_pkg::SRAM_REGION) begin
			sram_req.stb = cpu_req_i.stb;
			cpu_rsp_o    = sram_rsp;
		end else if (cpu_req_i.adr[29:26] == soc_pkg::PERI_REGION_NIBBLE) begin
			bridge_req.stb = cpu_req_i.stb;
			cpu_rsp_o      = bridge_rsp;
		end else begin
			// unmapped, immediate ack with zero
			cpu_rsp_o.dat = '0;
			cpu_rsp_o.ack = cpu_req_i.stb;
		end
	end

	bus_sram sram_i (
		.clk   (clk),
		.reset (reset),
		.req_i (sram_req),
		.rsp_o (sram_rsp)
	);

	bus_bridge bridge_i (
		.clk       (clk),
		.reset     (reset),
		.in_req_i  (bridge_req),
		.in_rsp_o  (bridge_rsp),
		.out_req_o (peri_req),
		.out_rsp_i (peri_rsp)
	);

	// ----------------------------------------
	// peripheral bus decoder
	// ----------------------------------------

	always_comb begin
		irc_req       = peri_req;
		irc_req.stb   = 1'b0;
		timer_req     = peri_req;
		timer_req.stb = 1'b0;
		if (peri_req.adr[29:22] == soc_pkg::IRC_REGION) begin
			irc_req.stb = peri_req.stb;
			peri_rsp    = irc_rsp;
		end else if (peri_req.adr[29:22] == soc_pkg::TIMER_REGION) begin
			timer_req.stb = peri_req.stb;
			peri_rsp      = timer_rsp;
		end else begin
			peri_rsp.dat = '0;
			peri_rsp.ack = peri_req.stb;
		end
	end

	// irq map, timer on factor 0
	assign irq_vec = {ext_irq_i, timer_irq};

	irq_controller irc_i (
		.clk           (clk),
		.reset         (reset),
		.irq_i         (irq_vec),
		.cpu_irq_o     (cpu_irq_o),
		.cpu_irq_ack_i (cpu_irq_ack_i),
		.req_i         (irc_req),
		.rsp_o         (irc_rsp)
	);

	interval_timer timer_i (
		.clk   (clk),
		.reset (reset),
		.irq_o (timer_irq),
		.req_i (timer_req),
		.rsp_o (timer_rsp)
	);

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

	// ----------------------------------------
	// bus types
	// ----------------------------------------

	// adr is the word address, byte address bits 31:2
	typedef struct packed {
		logic [29:0] adr;
		logic [31:0] dat;
		logic        we;
		logic [3:0]  sel;
		logic        stb;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} bus_rsp_t;

	// ----------------------------------------
	// address map, byte address bits 31:24
	// ----------------------------------------

	localparam logic [7:0] SRAM_REGION        = 8'h01;
	localparam logic [3:0] PERI_REGION_NIBBLE = 4'hf;
	localparam logic [7:0] IRC_REGION         = 8'hf0;
	localparam logic [7:0] TIMER_REGION       = 8'hf1;

	localparam int SRAM_ADR_BITS = 10;

	// factor 0 timer, factor 1 external pin
	localparam int IRQ_NUM     = 2;
	localparam int IRQ_ID_BITS = 1;

	// register word offsets
	localparam logic [1:0] IRC_REG_ENABLE  = 2'd0;
	localparam logic [1:0] IRC_REG_PENDING = 2'd1;
	localparam logic [1:0] IRC_REG_FACTOR  = 2'd2;

	localparam logic [1:0] TIMER_REG_CONTROL = 2'd0;
	localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;
	localparam logic [1:0] TIMER_REG_COUNTER = 2'd2;

endpackage

// File: sources.f
source/soc_pkg.sv
source/bus_sram.sv
source/bus_bridge.sv
source/irq_controller.sv
source/interval_timer.sv
source/soc_bus_top.sv
dv/tb_soc_bus.sv
